//--- serdes_loop_test.f
+incdir+rtl
rtl/serdes_test_pkg.sv
rtl/prbs_word_gen.sv
rtl/word_serializer.sv
rtl/loop_checker.sv
rtl/test_cfg_regs.sv
rtl/serdes_loop_test.sv
sim/tb_serdes_loop_test.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the loopback testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

TOP=tb_serdes_loop_test
LOG=sim.log

rm -rf obj_dir
verilator --binary -Wno-fatal --top-module "$TOP" -f serdes_loop_test.f -o "$TOP"

./obj_dir/"$TOP" | tee "$LOG"

if grep -qx "Test OK" "$LOG"; then
    echo "Simulation passed, log in $LOG"
    exit 0
else
    echo "Simulation failed, log in $LOG"
    exit 1
fi

//--- sim/tb_serdes_loop_test.sv
`include "serdes_test_cfg.svh"

module tb_serdes_loop_test;

    localparam int WORD_W       = `SERDES_WORD_W;
    localparam int HALF_PER     = 4;
    localparam int HOLD_RESET   = 16;
    localparam int MAX_HOLD     = 200;
    localparam int STREAM_WORDS = 64;
    localparam int CLEAN_CYCLES = 200;
    localparam int FAULT_CYCLES = 1200;
    localparam int OFF_CYCLES   = 128;
    localparam int RAND_SEED    = 32'h1003674b;
    // Budget per test, in the order the tests run
    localparam int TEST_CYCLES  = 16 + (8 + STREAM_WORDS * WORD_W) + (48 + CLEAN_CYCLES)
                                + (FAULT_CYCLES + 32) + (2 * MAX_HOLD + 96) + (OFF_CYCLES + 128);
    localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES;

    logic        CLK;
    logic        RST;
    logic        I_DAT;
    logic        O_DAT;
    logic        O_ERROR;
    logic        cfg_wr;
    logic [1:0]  cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] cfg_rdata;

    // Stream model and bookkeeping
    int          neg_cnt;
    logic [6:0]  model_st;
    int          exp_errs;
    int          checks;
    int          mismatches;
    int          tests_pass;
    int          tests_fail;

    serdes_loop_test dut0 (
        .CLK        (CLK),
        .RST        (RST),
        .I_DAT      (I_DAT),
        .O_DAT      (O_DAT),
        .O_ERROR    (O_ERROR),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata)
    );

    initial begin
        CLK = 1'b0;
        forever #HALF_PER CLK = ~CLK;
    end

    // Watchdog on rising edges
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test FAILED");
        $finish;
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    task automatic check(input string name, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
        checks++;
        if (act_val !== exp_val) begin
            mismatches++;
            $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, exp_val, act_val);
        end
    endtask

    // One falling edge: advance the model, check the pin, drive the loopback
    task automatic step(input logic fault);
        logic fb;
        logic exp_dat;
        @(negedge CLK);
        neg_cnt++;
        exp_dat = 1'b0;
        // First word_tick in cycle 8, its bit 0 on the pin one cycle later
        if (neg_cnt >= WORD_W) begin
            fb       = model_st[6] ^ model_st[5];
            model_st = {model_st[5:0], fb};
            exp_dat  = fb;
        end
        check("O_DAT", 32'(exp_dat), 32'(O_DAT));
        // Loopback wire with optional bit flip
        I_DAT = O_DAT ^ fault;
    endtask

    task automatic run_idle(input int n);
        repeat (n) step(1'b0);
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        step(1'b0);
        cfg_wr    = 1'b0;
        cfg_wdata = '0;
    endtask

    // Read mux is combinational, sampled on the next falling edge
    task automatic read_reg(input logic [1:0] addr, output logic [31:0] data);
        cfg_addr = addr;
        step(1'b0);
        data = cfg_rdata;
    endtask

    task automatic end_test(input string name, input int mark);
        if (mismatches == mark) begin
            tests_pass++;
            $display("test %s: pass", name);
        end else begin
            tests_fail++;
            $display("test %s: fail, %0d mismatches", name, mismatches - mark);
        end
    endtask

    // ======================================================================
    // Tests
    // ======================================================================

    task automatic test_reset_state();
        int          mark;
        logic [31:0] rd;
        mark = mismatches;
        check("O_ERROR", 32'd0, 32'(O_ERROR));
        read_reg(`SERDES_ADDR_CTRL, rd);
        check("ctrl", 32'd0, rd);
        read_reg(`SERDES_ADDR_HOLD, rd);
        check("hold_cycles", 32'(HOLD_RESET), rd);
        read_reg(`SERDES_ADDR_ERRCNT, rd);
        check("err_count", 32'd0, rd);
        end_test("reset_state", mark);
    endtask

    // Pin checked inside every step, so just run past the last bit of word 63
    task automatic test_output_stream();
        int mark;
        mark = mismatches;
        while (neg_cnt < WORD_W + STREAM_WORDS * WORD_W - 1) begin
            step(1'b0);
        end
        end_test("output_stream", mark);
    endtask

    task automatic test_clean_loopback();
        int          mark;
        int          polls;
        logic        armed;
        logic [31:0] rd;
        mark  = mismatches;
        polls = 0;
        armed = 1'b0;
        write_reg(`SERDES_ADDR_CTRL, 32'h1);
        // Poll armed once per cycle from the enable edge
        while (!armed && polls < 4 * WORD_W) begin
            read_reg(`SERDES_ADDR_CTRL, rd);
            polls++;
            armed = rd[2];
        end
        if (!armed) begin
            mismatches++;
            $display("Checker never armed within %0d cycles of enable", 4 * WORD_W);
        end else begin
            check("armed_delay", 32'(2 * WORD_W), 32'(polls));
        end
        repeat (CLEAN_CYCLES) begin
            step(1'b0);
            check("O_ERROR", 32'd0, 32'(O_ERROR));
        end
        read_reg(`SERDES_ADDR_ERRCNT, rd);
        check("err_count", 32'd0, rd);
        read_reg(`SERDES_ADDR_CTRL, rd);
        check("ctrl", 32'h5, rd);
        end_test("clean_loopback", mark);
    endtask

    task automatic test_fault_count();
        int          mark;
        int          faults;
        logic        flip;
        logic [31:0] rd;
        mark   = mismatches;
        faults = 0;
        // About one flipped bit in sixteen
        repeat (FAULT_CYCLES) begin
            flip = (($urandom % 16) == 0);
            if (flip) begin
                faults++;
            end
            step(flip);
        end
        run_idle(4);
        exp_errs += faults;
        read_reg(`SERDES_ADDR_ERRCNT, rd);
        check("err_count", 32'(exp_errs), rd);
        end_test("fault_count", mark);
    endtask

    task automatic test_error_hold();
        int          mark;
        int          hold_val;
        logic [31:0] rd;
        mark     = mismatches;
        hold_val = 1 + int'($urandom % MAX_HOLD);
        write_reg(`SERDES_ADDR_HOLD, 32'(hold_val));
        read_reg(`SERDES_ADDR_HOLD, rd);
        check("hold_cycles", 32'(hold_val), rd);
        // Let the stretch from the previous test run out
        run_idle(HOLD_RESET + 8);
        check("O_ERROR", 32'd0, 32'(O_ERROR));
        step(1'b1);
        // High from the second cycle after the flipped bit, hold_val cycles long
        for (int i = 1; i <= hold_val + 8; i++) begin
            step(1'b0);
            check("O_ERROR", 32'((i >= 2) && (i <= hold_val + 1)), 32'(O_ERROR));
        end
        exp_errs++;
        read_reg(`SERDES_ADDR_ERRCNT, rd);
        check("err_count", 32'(exp_errs), rd);
        // Zero length, still counted but flag stays low
        write_reg(`SERDES_ADDR_HOLD, 32'd0);
        step(1'b1);
        repeat (8) begin
            step(1'b0);
            check("O_ERROR", 32'd0, 32'(O_ERROR));
        end
        exp_errs++;
        read_reg(`SERDES_ADDR_ERRCNT, rd);
        check("err_count", 32'(exp_errs), rd);
        end_test("error_hold", mark);
    endtask

    task automatic test_clear_disable();
        int          mark;
        logic        flip;
        logic [31:0] rd;
        mark = mismatches;
        write_reg(`SERDES_ADDR_HOLD, 32'd6);
        // One fault so the hold timer is running when the clear lands
        step(1'b1);
        run_idle(2);
        check("O_ERROR", 32'd1, 32'(O_ERROR));
        // Enable kept on, clear bit set
        write_reg(`SERDES_ADDR_CTRL, 32'h3);
        step(1'b0);
        // Hold timer zeroed with the count
        check("O_ERROR", 32'd0, 32'(O_ERROR));
        exp_errs = 0;
        read_reg(`SERDES_ADDR_ERRCNT, rd);
        check("err_count", 32'(exp_errs), rd);
        repeat (3) begin
            step(1'b1);
            run_idle(10);
        end
        exp_errs = 3;
        read_reg(`SERDES_ADDR_ERRCNT, rd);
        check("err_count", 32'(exp_errs), rd);
        check("O_ERROR", 32'd0, 32'(O_ERROR));
        // Disable drops armed, count is kept
        write_reg(`SERDES_ADDR_CTRL, 32'h0);
        read_reg(`SERDES_ADDR_CTRL, rd);
        check("ctrl", 32'd0, rd);
        repeat (OFF_CYCLES) begin
            flip = (($urandom % 4) == 0);
            step(flip);
            check("O_ERROR", 32'd0, 32'(O_ERROR));
        end
        run_idle(4);
        read_reg(`SERDES_ADDR_ERRCNT, rd);
        check("err_count", 32'(exp_errs), rd);
        end_test("clear_disable", mark);
    endtask

    // ======================================================================
    // Sequence
    // ======================================================================

    initial begin : main
        RST        = 1'b1;
        I_DAT      = 1'b0;
        cfg_wr     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        neg_cnt    = 0;
        model_st   = `SERDES_PRBS_SEED;
        exp_errs   = 0;
        checks     = 0;
        mismatches = 0;
        tests_pass = 0;
        tests_fail = 0;
        void'($urandom(RAND_SEED));
        // Two cycles of reset, released on a falling edge
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;

        test_reset_state();
        test_output_stream();
        test_clean_loopback();
        test_fault_count();
        test_error_hold();
        test_clear_disable();

        $display("tests passed=%0d failed=%0d, checks=%0d mismatches=%0d",
                 tests_pass, tests_fail, checks, mismatches);
        if (tests_fail == 0 && mismatches == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/serdes_loop_test.sv
`include "serdes_test_cfg.svh"

module serdes_loop_test (
    input  logic                        CLK,
    input  logic                        RST,

    // Serial lane
    input  logic                        I_DAT,
    output logic                        O_DAT,

    // Error indicator
    output logic                        O_ERROR,

    // Configuration bus
    input  logic                        cfg_wr,
    input  logic [`SERDES_ADDR_W-1:0]   cfg_addr,
    input  logic [`SERDES_REG_W-1:0]    cfg_wdata,
    output logic [`SERDES_REG_W-1:0]    cfg_rdata
);

    logic                           word_tick;
    logic [`SERDES_WORD_W-1:0]      prbs_word;
    serdes_test_pkg::test_cfg_t     cfg;
    serdes_test_pkg::test_status_t  status;

    // ======================================================================
    // Pattern source
    // ======================================================================

    prbs_word_gen u_gen (
        .CLK        (CLK),
        .RST        (RST),
        .word_tick  (word_tick),
        .prbs_word  (prbs_word)
    );

    // ======================================================================
    // Transmit lane
    // ======================================================================

    word_serializer u_ser (
        .CLK        (CLK),
        .RST        (RST),
        .word_tick  (word_tick),
        .prbs_word  (prbs_word),
        .O_DAT      (O_DAT)
    );

    // ======================================================================
    // Receive check and control
    // ======================================================================

    // Reference fed from the same word and strobe as the lane
    loop_checker u_chk (
        .CLK        (CLK),
        .RST        (RST),
        .word_tick  (word_tick),
        .prbs_word  (prbs_word),
        .I_DAT      (I_DAT),
        .cfg        (cfg),
        .status     (status),
        .O_ERROR    (O_ERROR)
    );

    test_cfg_regs u_regs (
        .CLK        (CLK),
        .RST        (RST),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .cfg        (cfg),
        .status     (status)
    );

endmodule

//--- rtl/test_cfg_regs.sv
`include "serdes_test_cfg.svh"

module test_cfg_regs (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            cfg_wr,
    input  logic [`SERDES_ADDR_W-1:0]       cfg_addr,
    input  logic [`SERDES_REG_W-1:0]        cfg_wdata,
    output logic [`SERDES_REG_W-1:0]        cfg_rdata,
    output serdes_test_pkg::test_cfg_t      cfg,
    input  serdes_test_pkg::test_status_t   status
);

    localparam int HOLD_W = `SERDES_HOLD_W;
    localparam int ERR_W  = `SERDES_ERR_CNT_W;

    logic              ctrl_wr;
    logic              hold_wr;
    logic              enable_q;
    logic              clear_q;
    logic [HOLD_W-1:0] hold_q;

    // ======================================================================
    // Write side
    // ======================================================================

    // Address decode for the strobe cycle
    assign ctrl_wr = cfg_wr && (cfg_addr == `SERDES_ADDR_CTRL);
    assign hold_wr = cfg_wr && (cfg_addr == `SERDES_ADDR_HOLD);

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            enable_q <= 1'b0;
            clear_q  <= 1'b0;
            hold_q   <= HOLD_W'(`SERDES_HOLD_RESET);
        end else begin
            // Clear bit is self-clearing, high for the next cycle only
            clear_q <= ctrl_wr & cfg_wdata[1];
            if (ctrl_wr) begin
                enable_q <= cfg_wdata[0];
            end
            if (hold_wr) begin
                hold_q <= cfg_wdata[HOLD_W-1:0];
            end
        end
    end

    // Checker configuration
    assign cfg.enable      = enable_q;
    assign cfg.clear       = clear_q;
    assign cfg.hold_cycles = hold_q;

    // ======================================================================
    // Read side
    // ======================================================================

    // Plain decode, valid every cycle
    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            `SERDES_ADDR_CTRL: begin
                cfg_rdata[0] = enable_q;
                // Bit 1 is the clear strobe, reads zero
                cfg_rdata[2] = status.armed;
            end
            `SERDES_ADDR_HOLD: begin
                cfg_rdata[HOLD_W-1:0] = hold_q;
            end
            `SERDES_ADDR_ERRCNT: begin
                cfg_rdata[ERR_W-1:0] = status.err_count;
            end
            default: begin
                cfg_rdata = '0;
            end
        endcase
    end

endmodule

//--- rtl/loop_checker.sv
`include "serdes_test_cfg.svh"

module loop_checker (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            word_tick,
    input  logic [`SERDES_WORD_W-1:0]       prbs_word,
    input  logic                            I_DAT,
    input  serdes_test_pkg::test_cfg_t      cfg,
    output serdes_test_pkg::test_status_t   status,
    output logic                            O_ERROR
);

    localparam int WORD_W   = `SERDES_WORD_W;
    localparam int ERR_W    = `SERDES_ERR_CNT_W;
    localparam int HOLD_W   = `SERDES_HOLD_W;
    localparam int SETTLE   = 2 * WORD_W;
    localparam int SETTLE_W = $clog2(SETTLE + 1);

    logic                in_q;
    logic [WORD_W-1:1]   ref_sr;
    logic                ref_q;
    logic                ref_dly;
    logic [SETTLE_W-1:0] settle_cnt;
    logic                armed;
    logic                mismatch;
    logic [ERR_W-1:0]    err_count;
    logic [HOLD_W-1:0]   hold_cnt;

    // ======================================================================
    // Return bit capture
    // ======================================================================

    // Input flop on the pin
    always_ff @(posedge CLK) begin
        in_q <= I_DAT;
    end

    // ======================================================================
    // Reference serializer
    // ======================================================================

    // Same load and shift as the lane serializer
    always_ff @(posedge CLK) begin
        if (word_tick) begin
            ref_sr <= prbs_word[WORD_W-1:1];
            ref_q  <= prbs_word[0];
        end else begin
            ref_sr <= ref_sr >> 1;
            ref_q  <= ref_sr[1];
        end
    end

    // Extra stage matches the input flop
    always_ff @(posedge CLK) begin
        ref_dly <= ref_q;
    end

    // ======================================================================
    // Settling mask
    // ======================================================================

    // Counts from the enable edge, cleared when enable drops
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            settle_cnt <= '0;
            armed      <= 1'b0;
        end else if (!cfg.enable) begin
            settle_cnt <= '0;
            armed      <= 1'b0;
        end else if (!armed) begin
            if (settle_cnt == SETTLE_W'(SETTLE - 1)) begin
                armed <= 1'b1;
            end else begin
                settle_cnt <= settle_cnt + 1'b1;
            end
        end
    end

    // One comparison per cycle while armed
    // Enable term cuts counting in the cycle enable drops
    assign mismatch = armed & cfg.enable & (in_q ^ ref_dly);

    // ======================================================================
    // Error count and hold
    // ======================================================================

    // Saturates at all ones, clear has priority
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            err_count <= '0;
        end else if (cfg.clear) begin
            err_count <= '0;
        end else if (mismatch && (err_count != '1)) begin
            err_count <= err_count + 1'b1;
        end
    end

    // Reload on every mismatch, so the hold runs from the last one
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            hold_cnt <= '0;
        end else if (cfg.clear) begin
            hold_cnt <= '0;
        end else if (mismatch) begin
            hold_cnt <= cfg.hold_cycles;
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // Zero hold length never raises the flag
    assign O_ERROR = (hold_cnt != '0);

    // Status back to the register block
    assign status.err_count = err_count;
    assign status.armed     = armed;

endmodule

//--- rtl/word_serializer.sv
`include "serdes_test_cfg.svh"

module word_serializer (
    input  logic                        CLK,
    input  logic                        RST,
    input  logic                        word_tick,
    input  logic [`SERDES_WORD_W-1:0]   prbs_word,
    output logic                        O_DAT
);

    localparam int WORD_W = `SERDES_WORD_W;

    // Bit 0 goes straight to the output flop, shifter holds the rest
    logic [WORD_W-1:1] shift_q;
    logic              out_q;

    // ======================================================================
    // Parallel load, LSB first shift
    // ======================================================================

    // Reset keeps the pin low until the first word
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            shift_q <= '0;
        end else if (word_tick) begin
            shift_q <= prbs_word[WORD_W-1:1];
        end else begin
            shift_q <= shift_q >> 1;
        end
    end

    // ======================================================================
    // Output flop, as the IOB register would be
    // ======================================================================

    // Bit 0 bypasses the shifter so the word starts one cycle after the strobe
    // Otherwise take the bit the shifter presents next
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            out_q <= 1'b0;
        end else if (word_tick) begin
            out_q <= prbs_word[0];
        end else begin
            out_q <= shift_q[1];
        end
    end

    // Pin driven straight from a flop, no glitches
    assign O_DAT = out_q;

endmodule

//--- rtl/prbs_word_gen.sv
`include "serdes_test_cfg.svh"

module prbs_word_gen (
    input  logic                        CLK,
    input  logic                        RST,
    output logic                        word_tick,
    output logic [`SERDES_WORD_W-1:0]   prbs_word
);

    localparam int WORD_W  = `SERDES_WORD_W;
    localparam int PHASE_W = $clog2(WORD_W);
    localparam int PRBS_W  = 7;

    logic [PHASE_W-1:0] phase;
    logic [PRBS_W-1:0]  prbs_state;
    logic [PRBS_W-1:0]  prbs_next;

    // ======================================================================
    // Word strobe, stands in for the slow clock
    // ======================================================================

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            phase <= '0;
        end else if (word_tick) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // Last phase of the word, eighth cycle out of reset
    assign word_tick = (phase == PHASE_W'(WORD_W - 1));

    // ======================================================================
    // PRBS-7, x^7 + x^6 + 1, one word of steps per strobe
    // ======================================================================

    always_comb begin : prbs_unroll
        logic [PRBS_W-1:0] st;
        logic              fb;
        st        = prbs_state;
        fb        = 1'b0;
        prbs_word = '0;
        // First step lands in the LSB
        for (int i = 0; i < WORD_W; i++) begin
            fb           = st[PRBS_W-1] ^ st[PRBS_W-2];
            prbs_word[i] = fb;
            st           = {st[PRBS_W-2:0], fb};
        end
        prbs_next = st;
    end

    // Word held stable until the strobe has been taken
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            prbs_state <= `SERDES_PRBS_SEED;
        end else if (word_tick) begin
            prbs_state <= prbs_next;
        end
    end

endmodule

//--- rtl/serdes_test_pkg.sv
`include "serdes_test_cfg.svh"

package serdes_test_pkg;

    // ======================================================================
    // Checker configuration, written through the register block
    // ======================================================================

    typedef struct packed {
        // Level, checker runs while high
        logic                       enable;
        // Single cycle strobe
        logic                       clear;
        // O_ERROR stretch after the last mismatch
        logic [`SERDES_HOLD_W-1:0]  hold_cycles;
    } test_cfg_t;

    // ======================================================================
    // Checker status, read back by the register block
    // ======================================================================

    typedef struct packed {
        // Saturating mismatch count
        logic [`SERDES_ERR_CNT_W-1:0]   err_count;
        // Settling mask expired
        logic                           armed;
    } test_status_t;

endpackage

//--- rtl/serdes_test_cfg.svh
`ifndef SERDES_TEST_CFG_SVH
`define SERDES_TEST_CFG_SVH

// Serial word and status widths
`define SERDES_WORD_W       8
`define SERDES_ERR_CNT_W    16
`define SERDES_HOLD_W       24

// PRBS-7 reset state, must not be zero
`define SERDES_PRBS_SEED    7'h7F

// Register bus
`define SERDES_ADDR_W       2
`define SERDES_REG_W        32
`define SERDES_ADDR_CTRL    2'd0
`define SERDES_ADDR_HOLD    2'd1
`define SERDES_ADDR_ERRCNT  2'd2

// Error hold length out of reset
`define SERDES_HOLD_RESET   16

`endif
